/* Makefile */
# Verilator build and run of the bus subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_wbc_soc
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
src/wbc_pkg.sv
src/wbc_slave_if.sv
src/wbc_mem.sv
src/wbc_decode.sv
src/wbc_panel.sv
src/wbc_soc.sv
tests/tb_wbc_soc.sv

/* src/wbc_decode.sv */
/*
 * address decoder between the external master and the two slaves
 * purely combinational, strobes one slave and merges data and ack back
 */
`timescale 1ns/1ps

module wbc_decode import wbc_pkg::*;
(
   input  logic             cyc_i,
   input  logic             stb_i,
   input  logic             we_i,
   input  logic [WB_AW-1:0] adr_i,
   input  logic [WB_DW-1:0] dat_i,
   input  logic [WB_SW-1:0] sel_i,
   output logic [WB_DW-1:0] dat_o,
   output logic             ack_o,
   wbc_slave_if.master      mem_bus,
   wbc_slave_if.master      panel_bus
);

   logic req;                                 // active bus cycle
   logic mem_hit;
   logic panel_hit;
   logic nomap_stb;                           // nobody home

   assign req       = cyc_i & stb_i;
   assign mem_hit   = (adr_i[ADR_HI:MEM_AW+1] == MEM_TOP_BITS);       // below 0o040000
   assign panel_hit = (adr_i[ADR_HI:PANEL_LSB] == PANEL_BASE[ADR_HI:PANEL_LSB]);
   assign nomap_stb = req & ~mem_hit & ~panel_hit;

   // per slave strobes, regions never overlap
   assign mem_bus.stb   = req & mem_hit;
   assign panel_bus.stb = req & panel_hit;

   // shared request fields go to both slaves
   assign mem_bus.we      = we_i;
   assign mem_bus.adr     = adr_i;
   assign mem_bus.dat_w   = dat_i;
   assign mem_bus.sel     = sel_i;
   assign panel_bus.we    = we_i;
   assign panel_bus.adr   = adr_i;
   assign panel_bus.dat_w = dat_i;
   assign panel_bus.sel   = sel_i;

   // and-or read mux, unmapped returns zero
   assign dat_o = (mem_bus.stb   ? mem_bus.dat_r   : '0)
                | (panel_bus.stb ? panel_bus.dat_r : '0);

   // unmapped acks at once so the master never stalls
   assign ack_o = mem_bus.ack | panel_bus.ack | nomap_stb;

endmodule

/* src/wbc_mem.sv */
/*
 * 8K x 16 RAM slave with byte lane writes
 * writes ack at once, reads ack two cycles after strobe
 */
`timescale 1ns/1ps

module wbc_mem import wbc_pkg::*;
(
   input  logic        wb_clk,
   input  logic        rst_i,
   wbc_slave_if.slave  bus
);

   logic [WB_DW-1:0]  mem [0:2**MEM_AW-1];
   logic [MEM_AW-1:0] word_adr;               // byte address to word index
   logic [WB_DW-1:0]  rd_q;                   // registered read word
   logic [1:0]        ack_q;                  // read ack delay line

   assign word_adr = bus.adr[MEM_AW:1];

   // array port, lane gated write plus read every cycle
   always_ff @(posedge wb_clk)
   begin
      if (bus.stb & bus.we)
      begin
         for (int i = 0; i < WB_SW; i++)
         begin
            if (bus.sel[i])                   // untouched lanes keep old byte
               mem[word_adr][i*BYTE_W +: BYTE_W] <= bus.dat_w[i*BYTE_W +: BYTE_W];
         end
      end
      rd_q <= mem[word_adr];
   end

   // stage 1 sets after first strobe cycle, stage 2 one later
   // any gap in stb flushes the line so back to back reads still wait
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
         ack_q <= 2'b00;
      else
      begin
         ack_q[0] <= bus.stb;
         ack_q[1] <= bus.stb & ack_q[0];
      end
   end

   assign bus.ack   = bus.stb & (ack_q[1] | bus.we);  // write needs no wait
   assign bus.dat_r = rd_q;                            // valid with read ack

endmodule

/* src/wbc_panel.sv */
/*
 * front panel slave with two display words and a button input word
 * scans the display words onto a four digit seven segment display
 */
`timescale 1ns/1ps

module wbc_panel import wbc_pkg::*;
(
   input  logic              wb_clk,
   input  logic              rst_i,
   wbc_slave_if.slave        bus,
   input  logic [BTN_W-1:0]  btn_i,          // push buttons, raw
   output logic [7:0]        hex_o,          // segment lines, active low
   output logic [DIGITS-1:0] hsel_o          // digit select, active low
);

   logic [PANEL_OW-1:0] ofs;                 // word offset within panel
   logic [WB_DW-1:0]    disp0_q;             // digits 0 and 1
   logic [WB_DW-1:0]    disp1_q;             // digits 2 and 3
   logic [WB_DW-1:0]    btn_word;
   logic [SCAN_CW-1:0]  pre_q;               // scan prescaler
   logic [DIG_IW-1:0]   dig_q;               // current digit
   logic [WB_DW-1:0]    dig_word;            // display word for current digit
   logic [BYTE_W-1:0]   dig_byte;

   assign ofs      = bus.adr[PANEL_OW:1];
   assign btn_word = {{(WB_DW-BTN_W){1'b0}}, btn_i};

   // full word writes, sel ignored
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         disp0_q <= '0;
         disp1_q <= '0;
      end
      else if (bus.stb & bus.we)
      begin
         case (ofs)
            PANEL_DISP0_OFS: disp0_q <= bus.dat_w;
            PANEL_DISP1_OFS: disp1_q <= bus.dat_w;
            default: ;                       // button word is read only
         endcase
      end
   end

   always_comb
   begin
      case (ofs)
         PANEL_DISP0_OFS: bus.dat_r = disp0_q;
         PANEL_DISP1_OFS: bus.dat_r = disp1_q;
         PANEL_BTN_OFS:   bus.dat_r = btn_word;
         default:         bus.dat_r = '0;
      endcase
   end

   assign bus.ack = bus.stb;                 // zero wait states

   // digit steps once per SCAN_DIV clocks, 0 up to DIGITS-1 then wraps
   always_ff @(posedge wb_clk)
   begin
      if (rst_i)
      begin
         pre_q <= '0;
         dig_q <= '0;
      end
      else if (pre_q == SCAN_CW'(SCAN_DIV-1))
      begin
         pre_q <= '0;
         if (dig_q == DIG_IW'(DIGITS-1))
            dig_q <= '0;
         else
            dig_q <= dig_q + 1'b1;
      end
      else
         pre_q <= pre_q + 1'b1;
   end

   // digit k shows word k/2, low byte on even k and high byte on odd k
   assign dig_word = dig_q[DIG_IW-1] ? disp1_q : disp0_q;
   assign dig_byte = dig_q[0] ? dig_word[WB_DW-1 -: BYTE_W] : dig_word[BYTE_W-1:0];

   assign hex_o  = ~dig_byte;                // segments lit on low
   assign hsel_o = ~(DIGITS'(1) << dig_q);   // one zero at the active digit

endmodule

/* src/wbc_pkg.sv */
/*
 * bus widths, address map and front panel constants
 * shared by the decoder, the RAM and panel slaves and the top level
 */
package wbc_pkg;

   // wishbone bus widths
   localparam int WB_AW  = 17;                 // byte address, 16-bit space plus spare bit
   localparam int WB_DW  = 16;                 // data word
   localparam int WB_SW  = 2;                  // byte lanes
   localparam int BYTE_W = 8;

   // highest decoded address bit, bit 16 is not decoded
   localparam int ADR_HI = 15;

   // RAM region 0o000000..0o037777
   localparam int MEM_AW = 13;                 // 8K words, byte address bits 13:1
   localparam logic [ADR_HI-MEM_AW-1:0] MEM_TOP_BITS = 2'b00;  // bits 15:14

   // panel region 0o177700..0o177717
   localparam logic [ADR_HI:0] PANEL_BASE = 16'o177700;
   localparam int PANEL_LSB = 4;               // compare bits 15:4
   localparam int PANEL_OW  = 2;               // word offset from bits 2:1

   localparam logic [PANEL_OW-1:0] PANEL_DISP0_OFS = 2'd0;  // low display word
   localparam logic [PANEL_OW-1:0] PANEL_DISP1_OFS = 2'd1;  // high display word
   localparam logic [PANEL_OW-1:0] PANEL_BTN_OFS   = 2'd2;  // button input, read only

   // front panel io
   localparam int BTN_W  = 5;
   localparam int DIGITS = 4;
   localparam int DIG_IW = $clog2(DIGITS);

   // digit scan rate, kept short so a full round fits a short simulation
   localparam int SCAN_DIV = 16;
   localparam int SCAN_CW  = $clog2(SCAN_DIV);

endpackage

/* src/wbc_slave_if.sv */
/*
 * one decoded wishbone slave port
 * the decoder drives it through master, each slave answers through slave
 */
`timescale 1ns/1ps

interface wbc_slave_if import wbc_pkg::*; ();

   logic             stb;        // decoded strobe, cyc already folded in
   logic             we;         // write enable
   logic [WB_AW-1:0] adr;        // byte address
   logic [WB_DW-1:0] dat_w;      // write data
   logic [WB_SW-1:0] sel;        // byte lane select
   logic [WB_DW-1:0] dat_r;      // read data
   logic             ack;        // acknowledge, only while stb is high

   modport master
   (
      output stb, we, adr, dat_w, sel,
      input  dat_r, ack
   );

   modport slave
   (
      input  stb, we, adr, dat_w, sel,
      output dat_r, ack
   );

endinterface

/* src/wbc_soc.sv */
/*
 * bus subsystem top level, external wishbone master on plain ports
 * decoder routes each access to the RAM or the front panel
 */
`timescale 1ns/1ps

module wbc_soc import wbc_pkg::*;
(
   input  logic              wb_clk,         // bus clock
   input  logic              rst_i,          // sync reset, active high

   // external master
   input  logic              cyc_i,
   input  logic              stb_i,
   input  logic              we_i,
   input  logic [WB_AW-1:0]  adr_i,          // byte address, octal map
   input  logic [WB_DW-1:0]  dat_i,
   input  logic [WB_SW-1:0]  sel_i,
   output logic [WB_DW-1:0]  dat_o,
   output logic              ack_o,

   // front panel
   input  logic [BTN_W-1:0]  btn_i,
   output logic [7:0]        hex_o,
   output logic [DIGITS-1:0] hsel_o
);

   wbc_slave_if mem_bus ();                  // decoder to RAM
   wbc_slave_if panel_bus ();                // decoder to panel

   wbc_decode decode
   (
      .cyc_i     (cyc_i),
      .stb_i     (stb_i),
      .we_i      (we_i),
      .adr_i     (adr_i),
      .dat_i     (dat_i),
      .sel_i     (sel_i),
      .dat_o     (dat_o),
      .ack_o     (ack_o),
      .mem_bus   (mem_bus.master),
      .panel_bus (panel_bus.master)
   );

   // 8K words at 0o000000
   wbc_mem mem
   (
      .wb_clk (wb_clk),
      .rst_i  (rst_i),
      .bus    (mem_bus.slave)
   );

   // registers at 0o177700
   wbc_panel panel
   (
      .wb_clk (wb_clk),
      .rst_i  (rst_i),
      .bus    (panel_bus.slave),
      .btn_i  (btn_i),
      .hex_o  (hex_o),
      .hsel_o (hsel_o)
   );

endmodule

/* tests/tb_wbc_soc.sv */
/*
 * directed testbench for the bus subsystem top level
 * drives the external master ports on the falling edge and checks RAM, panel and scan
 */
`timescale 1ns/1ps

module tb_wbc_soc import wbc_pkg::*; ();

   localparam int CLK_HALF   = 4;                       // 8 ns period
   localparam int RST_CYCLES = 16;
   localparam int ACK_LIMIT  = 8;                       // slowest ack is a RAM read at 2
   localparam int SCAN_LIMIT = DIGITS * SCAN_DIV + 8;   // one scan round plus slack
   localparam int RUN_LIMIT  = 4000;                    // room for ~200 bus cycles and ~10 rounds
   localparam int RAM_WORDS  = 24;
   localparam logic [31:0] RAND_SEED = 32'hdc2a_d0e1;
   localparam logic [WB_AW-1:0] DISP0_ADR = 17'o177700;
   localparam logic [WB_AW-1:0] DISP1_ADR = 17'o177702;
   localparam logic [WB_AW-1:0] BTN_ADR   = 17'o177704;
   localparam logic [WB_AW-1:0] NOMAP_ADR = 17'o100000;  // hole between RAM and panel

   logic wb_clk, rst_i, cyc_i, stb_i, we_i, ack_o;
   logic [WB_AW-1:0]  adr_i;
   logic [WB_DW-1:0]  dat_i, dat_o;
   logic [WB_SW-1:0]  sel_i;
   logic [BTN_W-1:0]  btn_i;
   logic [7:0]        hex_o;
   logic [DIGITS-1:0] hsel_o;
   logic [WB_DW-1:0]  shadow [0:2**MEM_AW-1];           // expected RAM contents
   int err_cnt = 0, checks = 0, tests_run = 0, tests_bad = 0, test_base = 0, cycle_cnt = 0;

   wbc_soc uut (.*);

   initial
   begin
      wb_clk = 1'b0;
      forever #CLK_HALF wb_clk = ~wb_clk;
   end

   task automatic expect_equal(input string name, input logic [WB_DW-1:0] exp,
                               input logic [WB_DW-1:0] got);
      checks++;
      assert (got == exp)
      else
      begin
         $display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   // one access held until ack or ACK_LIMIT and sampled on falling edges
   task automatic bus_access(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [WB_DW-1:0] wdata, input logic [WB_SW-1:0] sel,
                             output logic [WB_DW-1:0] rdata);
      int waited;
      waited = 0;
      @(negedge wb_clk);                                 // idle cycle before each access
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      dat_i = wdata;
      sel_i = sel;
      do
      begin
         @(negedge wb_clk);
         waited++;
      end while (!ack_o && waited < ACK_LIMIT);
      rdata = dat_o;                                     // stable since last rising edge
      assert (ack_o)
      else
      begin
         $display("no ack from address %o within %0d cycles", adr, ACK_LIMIT);
         err_cnt++;
      end
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
   endtask

   task automatic write_word(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data,
                             input logic [WB_SW-1:0] sel);
      logic [WB_DW-1:0] unused;
      bus_access(1'b1, adr, data, sel, unused);
   endtask

   task automatic read_word(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
      bus_access(1'b0, adr, '0, 2'b11, data);
   endtask

   function automatic logic [WB_AW-1:0] ram_adr(input logic [MEM_AW-1:0] idx);
      return {{(WB_AW-MEM_AW-1){1'b0}}, idx, 1'b0};     // word index to byte address
   endfunction

   // digit k shows register k/2 with the low byte on even k and segments active low
   function automatic logic [7:0] digit_pattern(input int k, input logic [WB_DW-1:0] d0,
                                                input logic [WB_DW-1:0] d1);
      logic [WB_DW-1:0] word;
      word = (k / 2 == 0) ? d0 : d1;
      return (k % 2 == 0) ? ~word[7:0] : ~word[15:8];
   endfunction

   task automatic end_test(input string name);
      tests_run++;
      if (err_cnt == test_base)
         $display("test %s: ok", name);
      else
      begin
         tests_bad++;
         $display("test %s: %0d error(s)", name, err_cnt - test_base);
      end
      test_base = err_cnt;
   endtask

   task automatic reset_state();
      @(negedge wb_clk);
      expect_equal("hsel_o", 16'h000e, {12'b0, hsel_o});  // digit 0 selected
      expect_equal("hex_o", 16'h00ff, {8'b0, hex_o});     // blank while registers are zero
      repeat (3)
      begin
         @(negedge wb_clk);
         expect_equal("ack_o", '0, {15'b0, ack_o});
      end
      end_test("reset_state");
   endtask

   task automatic ram_words();
      logic [MEM_AW-1:0] idx_q [$];
      logic [MEM_AW-1:0] idx;
      logic [WB_DW-1:0]  data;
      for (int i = 0; i < RAM_WORDS; i++)
      begin
         idx  = MEM_AW'($urandom);
         data = WB_DW'($urandom);
         shadow[idx] = data;                             // repeats keep the last word
         idx_q.push_back(idx);
         write_word(ram_adr(idx), data, 2'b11);
      end
      foreach (idx_q[i])
      begin
         read_word(ram_adr(idx_q[i]), data);
         expect_equal($sformatf("dat_o ram[%0d]", idx_q[i]), shadow[idx_q[i]], data);
      end
      end_test("ram_words");
   endtask

   task automatic ram_lanes();
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] base, exp, data;
      adr  = 17'o001000;
      base = WB_DW'($urandom);
      write_word(adr, base, 2'b11);
      write_word(adr, ~base, 2'b01);                     // low lane flips
      exp = {base[15:8], ~base[7:0]};
      read_word(adr, data);
      expect_equal("dat_o lane 0", exp, data);
      write_word(adr, ~exp, 2'b10);                      // high lane flips
      exp = {~exp[15:8], exp[7:0]};
      read_word(adr, data);
      expect_equal("dat_o lane 1", exp, data);
      end_test("ram_lanes");
   endtask

   task automatic panel_regs();
      logic [WB_DW-1:0] d0, d1, data;
      logic [BTN_W-1:0] btn;
      d0  = WB_DW'($urandom);
      d1  = WB_DW'($urandom);
      btn = BTN_W'($urandom);
      @(negedge wb_clk);
      btn_i = btn;
      write_word(DISP0_ADR, d0, 2'b01);                  // sel ignored so the whole word lands
      write_word(DISP1_ADR, d1, 2'b11);
      read_word(DISP0_ADR, data);
      expect_equal("dat_o disp0", d0, data);
      read_word(DISP1_ADR, data);
      expect_equal("dat_o disp1", d1, data);
      read_word(BTN_ADR, data);
      expect_equal("dat_o buttons", {{(WB_DW-BTN_W){1'b0}}, btn}, data);
      end_test("panel_regs");
   endtask

   task automatic display_scan();
      logic [WB_DW-1:0]  d0, d1;
      logic [DIGITS-1:0] sel_exp;
      int waited;
      d0 = WB_DW'($urandom);
      d1 = WB_DW'($urandom);
      write_word(DISP0_ADR, d0, 2'b11);
      write_word(DISP1_ADR, d1, 2'b11);
      repeat (2)                                         // two full rounds including the wrap
      begin
         for (int k = 0; k < DIGITS; k++)
         begin
            waited = 0;
            do
            begin
               @(negedge wb_clk);
               waited++;
            end while (hsel_o[k] && waited < SCAN_LIMIT);
            sel_exp    = '1;                             // all digits dark
            sel_exp[k] = 1'b0;                           // except the one being shown
            assert (!hsel_o[k])
            else
            begin
               $display("digit %0d never selected within %0d cycles", k, SCAN_LIMIT);
               err_cnt++;
            end
            expect_equal("hsel_o", {12'b0, sel_exp}, {12'b0, hsel_o});
            expect_equal("hex_o", {8'b0, digit_pattern(k, d0, d1)}, {8'b0, hex_o});
         end
      end
      end_test("display_scan");
   endtask

   task automatic unmapped_access();
      logic [WB_DW-1:0] ram_val, data;
      ram_val = WB_DW'($urandom);
      write_word(17'o000000, ram_val, 2'b11);            // same word index as the hole
      write_word(DISP0_ADR, ~ram_val, 2'b11);            // same panel offset as the hole
      write_word(DISP1_ADR, ram_val ^ 16'hff00, 2'b11);
      write_word(NOMAP_ADR, ram_val ^ 16'h00ff, 2'b11);  // must land nowhere
      read_word(NOMAP_ADR, data);
      expect_equal("dat_o unmapped", '0, data);
      read_word(17'o000000, data);
      expect_equal("dat_o ram[0]", ram_val, data);
      read_word(DISP0_ADR, data);
      expect_equal("dat_o disp0", ~ram_val, data);
      read_word(DISP1_ADR, data);
      expect_equal("dat_o disp1", ram_val ^ 16'hff00, data);
      end_test("unmapped_access");
   endtask

   initial
   begin
      rst_i = 1'b1;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
      adr_i = '0;
      dat_i = '0;
      sel_i = '0;
      btn_i = '0;
      void'($urandom(RAND_SEED));
      repeat (RST_CYCLES) @(negedge wb_clk);
      rst_i = 1'b0;
      reset_state();
      ram_words();
      ram_lanes();
      panel_regs();
      display_scan();
      unmapped_access();
      $display("tests %0d, failing %0d, checks %0d, errors %0d",
               tests_run, tests_bad, checks, err_cnt);
      if (err_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // run watchdog
   initial
   begin
      while (cycle_cnt < RUN_LIMIT)
      begin
         @(posedge wb_clk);
         cycle_cnt++;
      end
      $display("timeout, run still busy after %0d cycles", RUN_LIMIT);
      $display("*** FAILED ***");
      $finish;
   end

endmodule
